//--- video_pkg.sv
// Shared widths, bus structs, pixel and colour types and the register map; import with video_pkg::*
`default_nettype none

package video_pkg;

    // ########################################
    // Widths
    localparam int pxl_w = 4;                   // Layer pixel, colour index
    localparam int col_w = 4;                   // One colour channel
    localparam int adr_w = 10;                  // Wishbone address
    localparam int dat_w = 16;                  // Wishbone data

    // ########################################
    // Wishbone classic
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [adr_w-1:0] adr;
        logic [dat_w-1:0] dat;
    } wb_req_t;                                 // Host to slave

    typedef struct packed {
        logic             ack;
        logic [dat_w-1:0] dat;
    } wb_rsp_t;                                 // Slave to host

    // ########################################
    // Video path
    typedef struct packed {
        logic [pxl_w-1:0] scr;                  // Scroll layer index
        logic [pxl_w-1:0] obj;                  // Object index, 0 is transparent
    } layer_pix_t;

    typedef struct packed {
        logic [col_w-1:0] red;
        logic [col_w-1:0] green;
        logic [col_w-1:0] blue;
    } rgb_t;

    typedef struct packed {
        logic lhbl;                             // High on visible columns
        logic lvbl;                             // High on visible lines
    } vid_sync_t;

    typedef struct packed {
        logic [7:0] scroll_x;
        logic [7:0] obj_x;
        logic [7:0] obj_y;
        logic [3:0] obj_color;
        logic [2:0] pal_sel;
    } layer_regs_t;

    // ########################################
    // Register map
    localparam logic [1:0] pg_red   = 2'd0;     // 0x000..0x0FF
    localparam logic [1:0] pg_green = 2'd1;     // 0x100..0x1FF
    localparam logic [1:0] pg_blue  = 2'd2;     // 0x200..0x2FF
    localparam logic [1:0] pg_regs  = 2'd3;     // Layer registers page

    localparam logic [adr_w-1:0] adr_scroll_x  = 10'h300;
    localparam logic [adr_w-1:0] adr_obj_x     = 10'h301;
    localparam logic [adr_w-1:0] adr_obj_y     = 10'h302;
    localparam logic [adr_w-1:0] adr_obj_color = 10'h303;
    localparam logic [adr_w-1:0] adr_pal_sel   = 10'h304;

endpackage

`default_nettype wire

//--- video_timing.sv
// Video timing generator: pixel clock enable, h/v counters and blanking flags for the whole board
`timescale 1ns/1ps
`default_nettype none

module video_timing import video_pkg::*; #(
    parameter int h_total = 384,
    parameter int h_vis   = 256,
    parameter int v_total = 264,
    parameter int v_vis   = 224,
    parameter int cen_div = 4
) (
    input  logic       clk,
    input  logic       rst,
    output logic       pxl_cen,
    output logic [8:0] h_cnt,
    output logic [8:0] v_cnt,
    output vid_sync_t  sync
);

    localparam int cw = $clog2(cen_div + 1);    // Divider counter width

    logic [cw-1:0] cen_cnt;
    logic          h_last;
    logic          v_last;

    // ########################################
    // Pixel clock enable
    assign pxl_cen = cen_cnt == cw'(cen_div - 1);   // One clk in cen_div

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt <= '0;
        end else if (pxl_cen) begin
            cen_cnt <= '0;                      // Wrap on the tick
        end else begin
            cen_cnt <= cen_cnt + 1'b1;
        end
    end

    // ########################################
    // Counters
    assign h_last = h_cnt == 9'(h_total - 1);   // Last column of the line
    assign v_last = v_cnt == 9'(v_total - 1);   // Last line of the frame

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pxl_cen) begin
            h_cnt <= h_last ? 9'd0 : h_cnt + 9'd1;
            if (h_last) begin
                v_cnt <= v_last ? 9'd0 : v_cnt + 9'd1;  // Next line
            end
        end
    end

    // Visible flags follow the counters directly
    assign sync.lhbl = h_cnt < 9'(h_vis);
    assign sync.lvbl = v_cnt < 9'(v_vis);

endmodule

`default_nettype wire

//--- pixel_gen.sv
// Stand-in pixel producer: scroll and object pixels from the counters, registered on each pixel tick
`timescale 1ns/1ps
`default_nettype none

module pixel_gen import video_pkg::*; #(
    parameter int obj_w = 16,
    parameter int obj_h = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic [8:0]  h_cnt,
    input  logic [8:0]  v_cnt,
    input  layer_regs_t regs,
    output layer_pix_t  pix
);

    logic [9:0]       h_ext;                    // Counters widened for box compare
    logic [9:0]       v_ext;
    logic [9:0]       x_lo;
    logic [9:0]       y_lo;
    logic             in_x;
    logic             in_y;
    logic [7:0]       scr_sum;
    logic [pxl_w-1:0] scr_nxt;
    logic [pxl_w-1:0] obj_nxt;

    // ########################################
    // Scroll layer
    assign scr_sum = h_cnt[7:0] + regs.scroll_x;    // Column plus scroll offset
    assign scr_nxt = scr_sum[pxl_w-1:0];            // Low nibble is the tile colour

    // ########################################
    // Object box
    assign h_ext = {1'b0, h_cnt};
    assign v_ext = {1'b0, v_cnt};
    assign x_lo  = {2'b0, regs.obj_x};
    assign y_lo  = {2'b0, regs.obj_y};

    assign in_x = (h_ext >= x_lo) && (h_ext < x_lo + 10'(obj_w));
    assign in_y = (v_ext >= y_lo) && (v_ext < y_lo + 10'(obj_h));

    assign obj_nxt = (in_x && in_y) ? regs.obj_color : '0;   // 0 outside, transparent

    always_ff @(posedge clk) begin
        if (rst) begin
            pix <= '0;
        end else if (pxl_cen) begin
            pix.scr <= scr_nxt;                 // Stage 1 of the colour path
            pix.obj <= obj_nxt;
        end
    end

endmodule

`default_nettype wire

//--- wb_prog.sv
// Wishbone classic slave for the layer registers and the palette PROM write port
`timescale 1ns/1ps
`default_nettype none

module wb_prog import video_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  wb_req_t          wb_req,
    output wb_rsp_t          wb_rsp,
    output layer_regs_t      regs,
    output logic [7:0]       prog_addr,
    output logic [col_w-1:0] prog_data,
    output logic [2:0]       prog_we
);

    logic             req;                      // Cycle and strobe both up
    logic             ack;
    logic             done;                     // Acked, waiting for stb to drop
    logic             start;                    // First clock of a transfer
    logic [dat_w-1:0] rd_nxt;
    logic [dat_w-1:0] rd_dat;

    assign req   = wb_req.cyc & wb_req.stb;
    assign start = req & ~ack & ~done;

    // ########################################
    // Read mux
    always_comb begin
        case (wb_req.adr)
            adr_scroll_x:  rd_nxt = dat_w'(regs.scroll_x);
            adr_obj_x:     rd_nxt = dat_w'(regs.obj_x);
            adr_obj_y:     rd_nxt = dat_w'(regs.obj_y);
            adr_obj_color: rd_nxt = dat_w'(regs.obj_color);
            adr_pal_sel:   rd_nxt = dat_w'(regs.pal_sel);
            default:       rd_nxt = '0;         // PROMs are write only
        endcase
    end

    // ########################################
    // Handshake and writes
    always_ff @(posedge clk) begin
        if (rst) begin
            ack     <= 1'b0;
            done    <= 1'b0;
            rd_dat  <= '0;
            regs    <= '0;
            prog_we <= '0;
        end else begin
            ack     <= start;                   // One clk after stb
            done    <= req & (done | ack);      // Held until stb falls
            prog_we <= '0;                      // Strobe lasts one clk
            if (start) begin
                rd_dat <= rd_nxt;
                if (wb_req.we) begin
                    case (wb_req.adr[9:8])
                        pg_red:   prog_we <= 3'b001;
                        pg_green: prog_we <= 3'b010;
                        pg_blue:  prog_we <= 3'b100;
                        default: begin
                            case (wb_req.adr)
                                adr_scroll_x:  regs.scroll_x  <= wb_req.dat[7:0];
                                adr_obj_x:     regs.obj_x     <= wb_req.dat[7:0];
                                adr_obj_y:     regs.obj_y     <= wb_req.dat[7:0];
                                adr_obj_color: regs.obj_color <= wb_req.dat[3:0];
                                adr_pal_sel:   regs.pal_sel   <= wb_req.dat[2:0];
                                default:       ;    // Unmapped, ignored
                            endcase
                        end
                    endcase
                end
            end
        end
    end

    // PROM address and data ride along with the strobe
    always_ff @(posedge clk) begin
        if (start) begin
            prog_addr <= wb_req.adr[7:0];
            prog_data <= wb_req.dat[col_w-1:0];
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_dat;

endmodule

`default_nettype wire

//--- pal_prom.sv
// Palette PROM model: host write port and a read registered on the pixel clock enable
`timescale 1ns/1ps
`default_nettype none

module pal_prom #(
    parameter int dw = 4,
    parameter int aw = 8
) (
    input  logic          clk,
    input  logic          cen,
    input  logic [dw-1:0] data,
    input  logic [aw-1:0] wr_addr,
    input  logic          we,
    input  logic [aw-1:0] rd_addr,
    output logic [dw-1:0] q
);

    logic [dw-1:0] mem [2**aw];                 // Palette entries

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;               // Programming ignores cen
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];                  // Stage 3 of the colour path
        end
    end

endmodule

`default_nettype wire

//--- blank_dly.sv
// Blanking delay line that keeps the sync flags aligned with the colour and blacks out blanked pixels
`timescale 1ns/1ps
`default_nettype none

module blank_dly import video_pkg::*; #(
    parameter int dly = 3
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      pxl_cen,
    input  vid_sync_t sync,
    input  rgb_t      rgb_in,
    output vid_sync_t sync_dly,
    output rgb_t      rgb_out
);

    vid_sync_t sr [dly];                        // One stage per pixel tick
    logic      vis;

    // ########################################
    // Shift register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dly; i++) begin
                sr[i] <= '0;                    // Blanked out of reset
            end
        end else if (pxl_cen) begin
            sr[0] <= sync;
            for (int i = 1; i < dly; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

    assign sync_dly = sr[dly-1];

    // ########################################
    // Colour gate
    assign vis     = sync_dly.lhbl & sync_dly.lvbl;     // Both visible
    assign rgb_out = vis ? rgb_in : '0;                 // Black in blanking

endmodule

`default_nettype wire

//--- colmix.sv
// Colour mixer: object over scroll priority, palette lookup in three PROMs and blanking delay
`timescale 1ns/1ps
`default_nettype none

module colmix import video_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             pxl_cen,
    input  logic [2:0]       pal_sel,
    input  layer_pix_t       pix,
    input  vid_sync_t        sync,
    input  logic [7:0]       prog_addr,
    input  logic [col_w-1:0] prog_data,
    input  logic [2:0]       prog_we,
    output rgb_t             rgb,
    output vid_sync_t        sync_dly
);

    logic           obj_blank;
    logic [pxl_w:0] mux;                        // Blank flag and pixel index
    logic [7:0]     pal_addr;
    rgb_t           raw;                        // PROM output before blanking

    // ########################################
    // Priority mux
    assign obj_blank = pix.obj == '0;           // Transparent object

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            mux[pxl_w]     <= obj_blank;        // Stage 2
            mux[pxl_w-1:0] <= obj_blank ? pix.scr : pix.obj;
        end
    end

    // Bank, flag, index; only two bank bits reach the PROM
    assign pal_addr = {1'b0, pal_sel[1:0], mux};

    // ########################################
    // Palette PROMs
    pal_prom #(.dw(col_w), .aw(8)) u_red (
        .clk     (clk),
        .cen     (pxl_cen),
        .data    (prog_data),
        .wr_addr (prog_addr),
        .we      (prog_we[0]),
        .rd_addr (pal_addr),
        .q       (raw.red)
    );

    pal_prom #(.dw(col_w), .aw(8)) u_green (
        .clk     (clk),
        .cen     (pxl_cen),
        .data    (prog_data),
        .wr_addr (prog_addr),
        .we      (prog_we[1]),
        .rd_addr (pal_addr),
        .q       (raw.green)
    );

    pal_prom #(.dw(col_w), .aw(8)) u_blue (
        .clk     (clk),
        .cen     (pxl_cen),
        .data    (prog_data),
        .wr_addr (prog_addr),
        .we      (prog_we[2]),
        .rd_addr (pal_addr),
        .q       (raw.blue)
    );

    // Three ticks, matching generator, mux and PROM
    blank_dly #(.dly(3)) u_blank (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .sync     (sync),
        .rgb_in   (raw),
        .sync_dly (sync_dly),
        .rgb_out  (rgb)
    );

endmodule

`default_nettype wire

//--- video_top.sv
// Video board top level: timing, pixel producer, Wishbone programming slave and colour mixer
`timescale 1ns/1ps
`default_nettype none

module video_top import video_pkg::*; #(
    parameter int h_total = 384,
    parameter int h_vis   = 256,
    parameter int v_total = 264,
    parameter int v_vis   = 224,
    parameter int cen_div = 4,
    parameter int obj_w   = 16,
    parameter int obj_h   = 16
) (
    input  logic      clk,
    input  logic      rst,
    input  wb_req_t   wb_req,
    output wb_rsp_t   wb_rsp,
    output rgb_t      rgb,
    output vid_sync_t sync_dly
);

    logic             pxl_cen;
    logic [8:0]       h_cnt;
    logic [8:0]       v_cnt;
    vid_sync_t        sync;                     // Undelayed blanking
    layer_pix_t       pix;
    layer_regs_t      regs;
    logic [7:0]       prog_addr;
    logic [col_w-1:0] prog_data;
    logic [2:0]       prog_we;

    video_timing #(
        .h_total (h_total),
        .h_vis   (h_vis),
        .v_total (v_total),
        .v_vis   (v_vis),
        .cen_div (cen_div)
    ) u_timing (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .h_cnt   (h_cnt),
        .v_cnt   (v_cnt),
        .sync    (sync)
    );

    pixel_gen #(.obj_w(obj_w), .obj_h(obj_h)) u_pixel (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .h_cnt   (h_cnt),
        .v_cnt   (v_cnt),
        .regs    (regs),
        .pix     (pix)
    );

    wb_prog u_prog (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .regs      (regs),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we)
    );

    colmix u_colmix (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pal_sel   (regs.pal_sel),
        .pix       (pix),
        .sync      (sync),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .rgb       (rgb),
        .sync_dly  (sync_dly)
    );

endmodule

`default_nettype wire

//--- video_sva.sv
// Bound assertions on the video_top ports for the Wishbone handshake and the blanked colour
`timescale 1ns/1ps
`default_nettype none

module video_sva import video_pkg::*; (
    input logic      clk,
    input logic      rst,
    input wb_req_t   wb_req,
    input wb_rsp_t   wb_rsp,
    input rgb_t      rgb,
    input vid_sync_t sync_dly
);

    logic req;                                  // Cycle and strobe both up

    assign req = wb_req.cyc & wb_req.stb;

    // ########################################
    // Wishbone handshake
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack stayed high for more than one cycle");

    ack_needs_stb: assert property (@(posedge clk) disable iff (rst) wb_rsp.ack |-> req)
        else $error("ack without cyc and stb");

    // ########################################
    // Blanking
    blank_black: assert property (@(posedge clk) disable iff (rst)
        !(sync_dly.lhbl && sync_dly.lvbl) |-> rgb == '0)
        else $error("rgb not zero while blanked");

endmodule

// Slave response and mixer outputs both reach the top level ports
bind video_top video_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .rgb      (rgb),
    .sync_dly (sync_dly)
);

`default_nettype wire

//--- tb_video.sv
// Testbench for video_top: Wishbone table with read-backs, then frame checks against a colour model
`timescale 1ns/1ps
`default_nettype none

module tb_video import video_pkg::*;;

    // Small screen for simulation
    localparam int h_total    = 24;
    localparam int h_vis      = 16;
    localparam int v_total    = 12;
    localparam int v_vis      = 8;
    localparam int cen_div    = 2;
    localparam int obj_w      = 4;
    localparam int obj_h      = 2;
    localparam int rst_cycles = 4;
    localparam int frame_clks = h_total * v_total * cen_div;   // Clocks per frame
    localparam int ack_wait   = 8;              // Clocks allowed for one ack

    typedef struct packed {
        logic        wr;
        logic [9:0]  adr;
        logic [15:0] dat;                       // Write data, or expected read data
    } bus_op_t;

    logic      clk;
    logic      rst;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    rgb_t      rgb;
    vid_sync_t sync_dly;

    bus_op_t     ops [$];                       // Bus table, both phases
    int          p2_start;                      // First op of the second phase
    int          limit    = 0;
    logic [31:0] lcg_state = 32'd18801;

    // Colour model state
    logic [3:0] red_mem   [256];
    logic [3:0] green_mem [256];
    logic [3:0] blue_mem  [256];
    int         m_scroll_x  = 0;
    int         m_obj_x     = 0;
    int         m_obj_y     = 0;
    int         m_obj_color = 0;
    int         m_pal_sel   = 0;

    // Bookkeeping, split by writing process
    string     cur_test = "startup";
    bit        chk_on   = 1'b0;
    int        bus_chk  = 0;
    int        bus_err  = 0;
    int        mon_chk  = 0;
    int        mon_err  = 0;
    int        chk_mark = 0;
    int        err_mark = 0;
    int        n_tests  = 0;
    int        n_failed = 0;
    int        x        = 0;                    // Monitor pixel position
    int        y        = 0;
    int        vis_cnt  = 0;
    int        frame_cnt = 0;
    vid_sync_t prev     = '0;

    video_top #(
        .h_total (h_total),
        .h_vis   (h_vis),
        .v_total (v_total),
        .v_vis   (v_vis),
        .cen_div (cen_div),
        .obj_w   (obj_w),
        .obj_h   (obj_h)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .rgb      (rgb),
        .sync_dly (sync_dly)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period
    end

    // ########################################
    // Helpers
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic bus_op_t mk_op(input logic wr, input logic [9:0] adr,
                                      input logic [15:0] dat);
        return '{wr: wr, adr: adr, dat: dat};
    endfunction

    function automatic bit check_val(input string test, input string what,
                                     input logic [31:0] exp, input logic [31:0] got);
        bit ok;
        ok = 1'b1;
        assert (got === exp) else begin
            $display("** Error %s %s: expected %h, actual %h", test, what, exp, got);
            ok = 1'b0;
        end
        return ok;
    endfunction

    // Expected colour of visible pixel x, y
    function automatic rgb_t model_rgb(input int px, input int py);
        logic [7:0] addr;
        logic       in_box;
        in_box = px >= m_obj_x && px < m_obj_x + obj_w && py >= m_obj_y && py < m_obj_y + obj_h;
        if (in_box && m_obj_color != 0) begin
            addr = 8'((m_pal_sel % 4) * 32 + m_obj_color);              // Flag 0, object index
        end else begin
            addr = 8'((m_pal_sel % 4) * 32 + 16 + (px + m_scroll_x) % 16);  // Flag 1, scroll
        end
        return '{red: red_mem[addr], green: green_mem[addr], blue: blue_mem[addr]};
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] got);
        bus_chk++;
        if (!check_val(cur_test, what, exp, got)) begin
            bus_err++;
        end
    endtask

    task automatic build_table();
        logic [15:0] val;
        for (int ch = 0; ch < 3; ch++) begin
            for (int a = 0; a < 128; a++) begin     // Only the low half is ever read
                val = 16'(lcg_next() >> 16) & 16'h000f;
                ops.push_back(mk_op(1'b1, 10'(ch * 256 + a), val));
            end
        end
        ops.push_back(mk_op(1'b1, adr_scroll_x, 16'h0035));
        ops.push_back(mk_op(1'b1, adr_obj_x, 16'h0006));
        ops.push_back(mk_op(1'b1, adr_obj_y, 16'h0003));
        ops.push_back(mk_op(1'b1, adr_obj_color, 16'h000b));
        ops.push_back(mk_op(1'b1, adr_pal_sel, 16'h0006));    // Top bit dropped, bank 2
        ops.push_back(mk_op(1'b0, adr_scroll_x, 16'h0035));
        ops.push_back(mk_op(1'b0, adr_obj_x, 16'h0006));
        ops.push_back(mk_op(1'b0, adr_obj_y, 16'h0003));
        ops.push_back(mk_op(1'b0, adr_obj_color, 16'h000b));
        ops.push_back(mk_op(1'b0, adr_pal_sel, 16'h0006));
        ops.push_back(mk_op(1'b0, 10'h005, 16'h0000));        // PROMs read as zero
        ops.push_back(mk_op(1'b0, 10'h1a0, 16'h0000));
        ops.push_back(mk_op(1'b0, 10'h2ff, 16'h0000));
        p2_start = ops.size();
        ops.push_back(mk_op(1'b1, adr_obj_color, 16'h0000));  // Box goes transparent
        ops.push_back(mk_op(1'b1, adr_pal_sel, 16'h0001));
        ops.push_back(mk_op(1'b1, adr_scroll_x, 16'h00c3));
        ops.push_back(mk_op(1'b0, adr_obj_color, 16'h0000));
        ops.push_back(mk_op(1'b0, adr_pal_sel, 16'h0001));
        ops.push_back(mk_op(1'b0, adr_scroll_x, 16'h00c3));
    endtask

    task automatic update_model(input bus_op_t op);
        case (op.adr[9:8])
            pg_red:   red_mem[op.adr[7:0]]   = op.dat[3:0];
            pg_green: green_mem[op.adr[7:0]] = op.dat[3:0];
            pg_blue:  blue_mem[op.adr[7:0]]  = op.dat[3:0];
            default: begin
                case (op.adr)
                    adr_scroll_x:  m_scroll_x  = int'(op.dat[7:0]);
                    adr_obj_x:     m_obj_x     = int'(op.dat[7:0]);
                    adr_obj_y:     m_obj_y     = int'(op.dat[7:0]);
                    adr_obj_color: m_obj_color = int'(op.dat[3:0]);
                    adr_pal_sel:   m_pal_sel   = int'(op.dat[2:0]);
                    default:       ;
                endcase
            end
        endcase
    endtask

    // Called on a rising edge, returns on the rising edge after ack has dropped
    task automatic apply_op(input bus_op_t op);
        int          waits;
        logic [15:0] rdat;
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: op.wr, adr: op.adr, dat: op.wr ? op.dat : 16'h0};
        waits = 0;
        do begin
            @(posedge clk);
            waits++;
        end while (!wb_rsp.ack && waits < ack_wait);
        bus_chk++;
        assert (wb_rsp.ack) else begin
            $display("No ack from the slave for address %h within %0d cycles", op.adr, ack_wait);
            bus_err++;
        end
        rdat = wb_rsp.dat;
        wb_req <= '0;                           // Master drops stb after ack
        @(posedge clk);
        expect_eq($sformatf("ack low after %h", op.adr), 32'h0, 32'(wb_rsp.ack));
        if (op.wr) begin
            update_model(op);
        end else begin
            expect_eq($sformatf("read %h", op.adr), 32'(op.dat), 32'(rdat));
        end
    endtask

    task automatic wait_frame_end();
        int f0;
        f0 = frame_cnt;
        wait (frame_cnt != f0);
        @(posedge clk);                         // Back onto the rising edge
    endtask

    task automatic end_test();
        int    errs;
        int    chks;
        string verdict;
        errs = bus_err + mon_err - err_mark;
        chks = bus_chk + mon_chk - chk_mark;
        n_tests++;
        if (errs != 0) begin
            n_failed++;
            verdict = "FAIL";
        end else begin
            verdict = "PASS";
        end
        $display("%s %s: %0d checks, %0d errors", verdict, cur_test, chks, errs);
        err_mark = bus_err + mon_err;
        chk_mark = bus_chk + mon_chk;
    endtask

    // ########################################
    // Output monitor, one sample per pixel tick
    always @(negedge clk) begin
        rgb_t exp_rgb;
        if (!rst && dut_i.pxl_cen) begin
            if (prev.lvbl && !sync_dly.lvbl) begin      // End of the visible frame
                if (chk_on) begin
                    mon_chk++;
                    if (!check_val(cur_test, "visible pixels per frame",
                                   32'(h_vis * v_vis), 32'(vis_cnt))) begin
                        mon_err++;
                    end
                end
                vis_cnt = 0;
                y = 0;
                frame_cnt++;
            end
            if (prev.lhbl && !sync_dly.lhbl) begin      // End of a line
                x = 0;
                if (sync_dly.lvbl) begin
                    y++;
                end
            end
            if (sync_dly.lhbl && sync_dly.lvbl) begin
                if (chk_on) begin
                    exp_rgb = model_rgb(x, y);
                    mon_chk++;
                    if (!check_val(cur_test, $sformatf("rgb at x %0d y %0d", x, y),
                                   32'(exp_rgb), 32'(rgb))) begin
                        mon_err++;
                    end
                end
                x++;
                vis_cnt++;
            end else begin
                mon_chk++;
                if (!check_val(cur_test, "rgb in blanking", 32'h0, 32'(rgb))) begin
                    mon_err++;
                end
            end
            prev = sync_dly;
        end
    end

    // ########################################
    // Run limit
    initial begin
        int cycles;
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run went past %0d clock cycles", limit);
        $display("Test failed");
        $finish;
    end

    // ########################################
    // Main sequence
    initial begin
        rst    <= 1'b1;
        wb_req <= '0;
        build_table();
        limit = rst_cycles + 3 * frame_clks + 4 * ops.size();
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;

        cur_test = "reset_state";
        @(negedge clk);                         // Still before the first pixel tick
        expect_eq("ack", 32'h0, 32'(wb_rsp.ack));
        expect_eq("sync_dly", 32'h0, 32'(sync_dly));
        expect_eq("rgb", 32'h0, 32'(rgb));
        end_test();

        cur_test = "bus_access";
        @(posedge clk);
        for (int i = 0; i < p2_start; i++) begin
            apply_op(ops[i]);
        end
        end_test();

        cur_test = "frame_scroll_obj";
        wait_frame_end();                       // Start on a clean frame
        chk_on = 1'b1;
        wait_frame_end();
        end_test();

        cur_test = "frame_new_palette";
        for (int i = p2_start; i < ops.size(); i++) begin
            apply_op(ops[i]);                   // Lands inside vertical blanking
        end
        wait_frame_end();
        chk_on = 1'b0;
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, bus_chk + mon_chk, bus_err + mon_err);
        if (n_failed == 0 && bus_err + mon_err == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
video_pkg.sv
video_timing.sv
pixel_gen.sv
wb_prog.sv
pal_prom.sv
blank_dly.sv
colmix.sv
video_top.sv
video_sva.sv
tb_video.sv

//--- Makefile
SIM      ?= verilator
TOP      ?= tb_video
FILELIST ?= tb.f
FLAGS    ?= --binary --timing --assert -j 0
BUILD    ?= obj_dir
PASS_MSG := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
